/* verilog.f */
+incdir+testbench
design/stackPkg.sv
design/stackStorage.sv
design/stackControl.sv
design/stackApbRegs.sv
design/stackSubsystem.sv
testbench/stackTb.sv

/* run.sh */
#!/bin/sh
# build the stack testbench with Verilator, run it and grade the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module stackTb -o stackTb

./obj_dir/stackTb > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* testbench/stackApbTasks.svh */
// APB master tasks for the stack testbench
// one transfer per call, driven on the falling edge and sampled 1 ns
// later; every wait for pready is bounded by readyTimeout cycles
`ifndef STACK_APB_TASKS_SVH
`define STACK_APB_TASKS_SVH

localparam int readyTimeout = 50;

task automatic busTransfer(input logic write, input logic [6:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err, output int waits);
  waits = 0;
  @(negedge clk); // setup phase
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(negedge clk);
  penable = 1'b1; // access phase
  #1;
  while (!pready && waits < readyTimeout) begin
    @(negedge clk);
    #1;
    waits++;
  end
  if (!pready) begin
    $display("no pready from address %h after %0d cycles", addr, waits);
    timeoutCount++;
  end
  rdata = prdata;
  err   = pslverr;
  @(negedge clk); // transfer done on the edge before
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic writeReg(input logic [6:0] addr, input logic [31:0] data,
                        output logic err, output int waits);
  logic [31:0] ignored;
  busTransfer(1'b1, addr, data, ignored, err, waits);
endtask

task automatic readReg(input logic [6:0] addr, output logic [31:0] data, output logic err);
  int waits;
  busTransfer(1'b0, addr, 32'h0, data, err, waits);
endtask

`endif

/* testbench/stackTb.sv */
// stack subsystem testbench
// applies a table of operand values and commands over APB, waits for
// busy to clear, and compares tos, out1, out2, index and status against
// values worked out by hand from the operation rules
`timescale 1ns/1ps

module stackTb;

  localparam int pollLimit = 40; // status reads while waiting on busy

  typedef struct packed {
    int         data;
    int         offset;
    int         uflow;
    int         upper;
    int         lower;
    logic [2:0] op;
    int         dropTos;
    int         stall;      // probe back-pressure during a long fill
    int         reps;
    int         expTos;
    int         expOut1;
    int         expOut2;
    int         expIndex;
    logic [2:0] expStatus;
  } rowT;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [6:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int  errorCount = 0;
  int  timeoutCount = 0;
  rowT rows[$];

  `include "stackApbTasks.svh"

  stackSubsystem #(.dataWidth(8), .depthLog2(3)) stackSubsystem_i (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic checkValue(input int step, input string name,
                            input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s at step %0d expected %h got %h", name, step, exp, got);
      errorCount++;
    end
  endtask

  // poll status until busy clears and hand back the last status word
  task automatic waitIdle(output logic [31:0] statusWord);
    logic err;
    int   polls;
    polls = 0;
    readReg(stackPkg::regStatus, statusWord, err);
    while (statusWord[stackPkg::statusBusyBit] && polls < pollLimit) begin
      readReg(stackPkg::regStatus, statusWord, err);
      polls++;
    end
    if (statusWord[stackPkg::statusBusyBit]) begin
      $display("busy still set after %0d status reads", polls);
      timeoutCount++;
    end
  endtask

  task automatic addRow(input int data, input int offset, input int uflow, input int upper,
                        input int lower, input logic [2:0] op, input int dropTos,
                        input int stall, input int reps, input int expTos, input int expOut1,
                        input int expOut2, input int expIndex, input logic [2:0] expStatus);
    rowT r;
    r = '{data, offset, uflow, upper, lower, op, dropTos, stall, reps,
          expTos, expOut1, expOut2, expIndex, expStatus};
    rows.push_back(r);
  endtask

  task automatic buildTable();
    // data, offset, uflow, upper, lower, op, drop, stall, reps
    // then tos, out1, out2, index, status
    addRow(0, 0, 0, 0, 0, stackPkg::opNone, 0, 0, 1,
           'h00, 'h00, 'h00, 0, stackPkg::stEmpty);
    addRow('h11, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 1,
           'h11, 'h00, 'h00, 1, stackPkg::stNone);
    addRow('h22, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 1,
           'h22, 'h11, 'h00, 2, stackPkg::stNone);
    addRow('h33, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 1,
           'h33, 'h22, 'h11, 3, stackPkg::stNone);
    addRow('h5A, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 11, // up to entry 13
           'h5A, 'h5A, 'h5A, 14, stackPkg::stNone);
    addRow('hEE, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 1,
           'hEE, 'h5A, 'h5A, 15, stackPkg::stFull);
    addRow('h77, 0, 0, 0, 0, stackPkg::opPush, 0, 0, 1,
           'hEE, 'h5A, 'h5A, 15, stackPkg::stOverflow);
    addRow(2, 0, 0, 0, 0, stackPkg::opPop, 0, 0, 1,
           'h5A, 'h5A, 'h5A, 12, stackPkg::stNone);
    addRow(8, 0, 0, 0, 0, stackPkg::opPop, 0, 0, 1,
           'h33, 'h22, 'h11, 3, stackPkg::stNone);
    addRow(2, 0, 1, 0, 0, stackPkg::opPop, 0, 0, 1, // 3 - 2 hits the limit
           'h33, 'h22, 'h11, 3, stackPkg::stUnderflow);
    addRow('h99, 0, 0, 0, 0, stackPkg::opReplace, 0, 0, 1,
           'h99, 'h22, 'h11, 3, stackPkg::stNone);
    addRow('h55, 0, 3, 0, 0, stackPkg::opReplace, 0, 0, 1,
           'h99, 'h22, 'h11, 3, stackPkg::stUnderflow);
    addRow(0, 0, 0, 0, 0, stackPkg::opPop, 0, 0, 1,
           'h22, 'h11, 'h00, 2, stackPkg::stNone);
    addRow(0, 9, 0, 0, 0, stackPkg::opIndexReset, 0, 1, 1, // clears 2 to 8
           'h00, 'h00, 'h00, 9, stackPkg::stNone);
    addRow('hA4, 4, 0, 0, 0, stackPkg::opIndexResetPush, 0, 0, 1,
           'hA4, 'h00, 'h00, 5, stackPkg::stNone);
    addRow('hB7, 7, 0, 0, 0, stackPkg::opIndexResetPush, 0, 0, 1, // short fill
           'hB7, 'h00, 'h00, 8, stackPkg::stNone);
    addRow('hF0, 15, 0, 0, 0, stackPkg::opIndexResetPush, 0, 0, 1,
           'hB7, 'h00, 'h00, 8, stackPkg::stOverflow);
    addRow('hC5, 3, 0, 10, 2, stackPkg::opUnderflowSet, 0, 0, 1, // entry 5
           'hB7, 'h00, 'hC5, 8, stackPkg::stNone);
    addRow('hC5, 3, 0, 10, 2, stackPkg::opUnderflowGet, 0, 0, 1,
           'hC5, 'h00, 'hC5, 8, stackPkg::stNone);
    addRow(0, 8, 0, 10, 2, stackPkg::opUnderflowGet, 0, 0, 1,
           'hC5, 'h00, 'hC5, 8, stackPkg::stBadOffset);
    addRow('hD3, 1, 0, 10, 2, stackPkg::opUnderflowSet, 1, 0, 1,
           'h00, 'hC5, 'hA4, 7, stackPkg::stNone);
    addRow('hE0, 1, 7, 10, 2, stackPkg::opUnderflowSet, 1, 0, 1,
           'h00, 'hC5, 'hA4, 7, stackPkg::stUnderflow);
  endtask

  initial begin
    rowT         r;
    logic [31:0] word;
    logic [31:0] cmdWord;
    logic        err;
    int          waits;
    int          step;

    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    buildTable();
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // state straight out of reset
    readReg(stackPkg::regIndex, word, err);
    checkValue(0, "index", word, 0);
    readReg(stackPkg::regStatus, word, err);
    checkValue(0, "status", word, 32'(stackPkg::stEmpty)); // busy bit low too

    for (int i = 0; i < rows.size(); i++) begin
      r    = rows[i];
      step = i + 1;
      writeReg(stackPkg::regData, r.data, err, waits);
      writeReg(stackPkg::regOffset, r.offset, err, waits);
      writeReg(stackPkg::regUnderflowLimit, r.uflow, err, waits);
      writeReg(stackPkg::regUpperLimit, r.upper, err, waits);
      writeReg(stackPkg::regLowerLimit, r.lower, err, waits);
      cmdWord = 32'(r.op) | (r.dropTos << stackPkg::cmdDropTosBit);
      for (int k = 0; k < r.reps; k++) begin
        writeReg(stackPkg::regCommand, cmdWord, err, waits);
        checkValue(step, "pslverr", 32'(err), 0);
        if (r.stall != 0) begin
          readReg(stackPkg::regStatus, word, err);
          checkValue(step, "busy", 32'(word[stackPkg::statusBusyBit]), 1);
          writeReg(stackPkg::regCommand, 32'(stackPkg::opNone), err, waits);
          assert (waits > 0) else begin
            $display("command write at step %0d was not held off during the fill", step);
            errorCount++;
          end
        end
        waitIdle(word);
      end
      checkValue(step, "status", word, 32'(r.expStatus));
      readReg(stackPkg::regTos, word, err);
      checkValue(step, "tos", word, r.expTos);
      readReg(stackPkg::regOut1, word, err);
      checkValue(step, "out1", word, r.expOut1);
      readReg(stackPkg::regOut2, word, err);
      checkValue(step, "out2", word, r.expOut2);
      readReg(stackPkg::regIndex, word, err);
      checkValue(step, "index", word, r.expIndex);
    end

    // operand registers hold the last row's values
    step = rows.size() + 1;
    readReg(stackPkg::regData, word, err);
    checkValue(step, "data", word, 'hE0);
    readReg(stackPkg::regOffset, word, err);
    checkValue(step, "offset", word, 1);
    readReg(stackPkg::regUnderflowLimit, word, err);
    checkValue(step, "underflowLimit", word, 7);
    readReg(stackPkg::regUpperLimit, word, err);
    checkValue(step, "upperLimit", word, 10);
    readReg(stackPkg::regLowerLimit, word, err);
    checkValue(step, "lowerLimit", word, 2);

    // bus errors leave the state alone
    writeReg(stackPkg::regTos, 32'hFF, err, waits);
    checkValue(step, "pslverr", 32'(err), 1);
    readReg(7'h2C, word, err); // past the last register
    checkValue(step, "pslverr", 32'(err), 1);
    readReg(stackPkg::regTos, word, err);
    checkValue(step, "tos", word, 0);
    readReg(stackPkg::regIndex, word, err);
    checkValue(step, "index", word, 7);

    $display("checks done: %0d value errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* design/stackSubsystem.sv */
// stack subsystem
// APB register block, operation sequencer and entry storage of the
// memory-mapped operand stack
`timescale 1ns/1ps

module stackSubsystem #(
  parameter int dataWidth = 8,
  parameter int depthLog2 = 3
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [stackPkg::apbAddrWidth-1:0] paddr,
  input  logic [stackPkg::apbDataWidth-1:0] pwdata,
  output logic [stackPkg::apbDataWidth-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr
);

  // launch side
  logic                 opValid;
  logic [2:0]           op;
  logic                 dropTos;
  logic [dataWidth-1:0] opData;
  logic [depthLog2:0]   opOffset;
  logic [depthLog2:0]   underflowLimit;
  logic [depthLog2:0]   upperLimit;
  logic [depthLog2:0]   lowerLimit;

  // results
  logic                 busy;
  logic [depthLog2:0]   index;
  logic [2:0]           status;
  logic [dataWidth-1:0] tos;
  logic [dataWidth-1:0] out1;
  logic [dataWidth-1:0] out2;

  // storage ports
  logic [depthLog2:0]   rdAddrA;
  logic [depthLog2:0]   rdAddrB;
  logic [depthLog2:0]   rdAddrC;
  logic [dataWidth-1:0] rdDataA;
  logic [dataWidth-1:0] rdDataB;
  logic [dataWidth-1:0] rdDataC;
  logic                 wrEn;
  logic [depthLog2:0]   wrAddr;
  logic [dataWidth-1:0] wrData;

  stackApbRegs #(.dataWidth(dataWidth), .depthLog2(depthLog2)) stackApbRegs_i (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .busy, .index, .status, .tos, .out1, .out2,
    .opValid, .op, .dropTos, .opData, .opOffset,
    .underflowLimit, .upperLimit, .lowerLimit
  );

  stackControl #(.dataWidth(dataWidth), .depthLog2(depthLog2)) stackControl_i (
    .clk, .reset,
    .opValid, .op, .dropTos, .opData, .opOffset,
    .underflowLimit, .upperLimit, .lowerLimit,
    .rdDataA, .rdDataB, .rdDataC,
    .busy, .index, .status, .tos, .out1, .out2,
    .rdAddrA, .rdAddrB, .rdAddrC,
    .wrEn, .wrAddr, .wrData
  );

  stackStorage #(.dataWidth(dataWidth), .depthLog2(depthLog2)) stackStorage_i (
    .clk, .wrEn, .wrAddr, .wrData,
    .rdAddrA, .rdAddrB, .rdAddrC,
    .rdDataA, .rdDataB, .rdDataC
  );

endmodule

/* design/stackApbRegs.sv */
// stack APB registers
// APB slave holding the operand registers; a command write launches one
// stack operation and is held off through pready while a zero fill runs,
// the results read back zero extended
`timescale 1ns/1ps

module stackApbRegs #(
  parameter int dataWidth = 8,
  parameter int depthLog2 = 3
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [stackPkg::apbAddrWidth-1:0] paddr,
  input  logic [stackPkg::apbDataWidth-1:0] pwdata,
  output logic [stackPkg::apbDataWidth-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  logic                              busy,
  input  logic [depthLog2:0]                index,
  input  logic [2:0]                        status,
  input  logic [dataWidth-1:0]              tos,
  input  logic [dataWidth-1:0]              out1,
  input  logic [dataWidth-1:0]              out2,
  output logic                              opValid,
  output logic [2:0]                        op,
  output logic                              dropTos,
  output logic [dataWidth-1:0]              opData,
  output logic [depthLog2:0]                opOffset,
  output logic [depthLog2:0]                underflowLimit,
  output logic [depthLog2:0]                upperLimit,
  output logic [depthLog2:0]                lowerLimit
);

  logic access;
  logic cmdWrite;
  logic mapped;
  logic readOnly;

  assign access   = psel && penable;
  assign cmdWrite = psel && pwrite && (paddr == stackPkg::regCommand);

  // only command writes wait, and only while the fill is running
  assign pready  = !(cmdWrite && busy);
  assign opValid = access && cmdWrite && !busy;
  assign op      = pwdata[stackPkg::cmdOpMsb:stackPkg::cmdOpLsb];
  assign dropTos = pwdata[stackPkg::cmdDropTosBit];
  assign pslverr = access && (!mapped || (pwrite && readOnly));

  always_ff @(posedge clk) begin
    if (reset) begin
      opData         <= '0;
      opOffset       <= '0;
      underflowLimit <= '0;
      upperLimit     <= '0;
      lowerLimit     <= '0;
    end else if (access && pwrite) begin
      case (paddr)
        stackPkg::regData:           opData         <= pwdata[dataWidth-1:0];
        stackPkg::regOffset:         opOffset       <= pwdata[depthLog2:0];
        stackPkg::regUnderflowLimit: underflowLimit <= pwdata[depthLog2:0];
        stackPkg::regUpperLimit:     upperLimit     <= pwdata[depthLog2:0];
        stackPkg::regLowerLimit:     lowerLimit     <= pwdata[depthLog2:0];
        default: ;
      endcase
    end
  end

  // readback and address decode
  always_comb begin
    prdata   = '0;
    mapped   = 1'b1;
    readOnly = 1'b0;
    case (paddr)
      stackPkg::regData:           prdata[dataWidth-1:0] = opData;
      stackPkg::regOffset:         prdata[depthLog2:0]   = opOffset;
      stackPkg::regUnderflowLimit: prdata[depthLog2:0]   = underflowLimit;
      stackPkg::regUpperLimit:     prdata[depthLog2:0]   = upperLimit;
      stackPkg::regLowerLimit:     prdata[depthLog2:0]   = lowerLimit;
      stackPkg::regCommand:        prdata                = '0; // nothing stored
      stackPkg::regTos: begin
        prdata[dataWidth-1:0] = tos;
        readOnly              = 1'b1;
      end
      stackPkg::regOut1: begin
        prdata[dataWidth-1:0] = out1;
        readOnly              = 1'b1;
      end
      stackPkg::regOut2: begin
        prdata[dataWidth-1:0] = out2;
        readOnly              = 1'b1;
      end
      stackPkg::regIndex: begin
        prdata[depthLog2:0] = index;
        readOnly            = 1'b1;
      end
      stackPkg::regStatus: begin
        prdata[stackPkg::statusMsb:stackPkg::statusLsb] = status;
        prdata[stackPkg::statusBusyBit]                 = busy;
        readOnly                                        = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

endmodule

/* design/stackControl.sv */
// stack control
// decodes each launched operation, keeps the index, the status and the
// registered top three entries, and runs the one entry per cycle zero
// fill of an index reset while holding busy
`timescale 1ns/1ps

module stackControl #(
  parameter int dataWidth = 8,
  parameter int depthLog2 = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 opValid,
  input  logic [2:0]           op,
  input  logic                 dropTos,
  input  logic [dataWidth-1:0] opData,
  input  logic [depthLog2:0]   opOffset,
  input  logic [depthLog2:0]   underflowLimit,
  input  logic [depthLog2:0]   upperLimit,
  input  logic [depthLog2:0]   lowerLimit,
  input  logic [dataWidth-1:0] rdDataA,
  input  logic [dataWidth-1:0] rdDataB,
  input  logic [dataWidth-1:0] rdDataC,
  output logic                 busy,
  output logic [depthLog2:0]   index,
  output logic [2:0]           status,
  output logic [dataWidth-1:0] tos,
  output logic [dataWidth-1:0] out1,
  output logic [dataWidth-1:0] out2,
  output logic [depthLog2:0]   rdAddrA,
  output logic [depthLog2:0]   rdAddrB,
  output logic [depthLog2:0]   rdAddrC,
  output logic                 wrEn,
  output logic [depthLog2:0]   wrAddr,
  output logic [dataWidth-1:0] wrData
);

  localparam int indexWidth = depthLog2 + 1;
  localparam int maxStack   = 2 ** indexWidth - 1;
  localparam int sumWidth   = (dataWidth > indexWidth ? dataWidth : indexWidth) + 1;
  localparam logic [indexWidth-1:0] topIndex = indexWidth'(maxStack);

  // zero fill state
  logic [indexWidth-1:0] clrAddr;   // next entry to clear
  logic [indexWidth-1:0] clrTarget; // index once the fill is done
  logic                  clrPush;
  logic [dataWidth-1:0]  clrData;
  logic                  clrLast;

  logic                  startClear;
  logic                  doRefresh;
  logic                  doGet;
  logic                  doError;
  logic [2:0]            errCode;
  logic [indexWidth-1:0] nextIndex;
  logic [indexWidth-1:0] getAddr;
  logic                  badOffset;
  logic [sumWidth-1:0]   popSum;
  logic                  popUnder;
  logic [dataWidth-1:0]  fwdA;
  logic [dataWidth-1:0]  fwdB;
  logic [dataWidth-1:0]  fwdC;

  function automatic logic [2:0] levelStatus(input logic [indexWidth-1:0] idx,
                                             input logic [indexWidth-1:0] limit);
    if (idx == topIndex) return stackPkg::stFull;
    if (idx == limit) return stackPkg::stEmpty;
    if (idx < limit) return stackPkg::stUnderflow;
    return stackPkg::stNone;
  endfunction

  assign getAddr   = lowerLimit + opOffset;
  // widened so that upper below lower never wraps into a good offset
  assign badOffset = ({1'b0, lowerLimit} + {1'b0, opOffset}) >= {1'b0, upperLimit};
  assign popSum    = sumWidth'(opData) + sumWidth'(underflowLimit);
  assign popUnder  = popSum >= sumWidth'(index); // index - data <= limit
  assign clrLast   = clrAddr == clrTarget;

  always_comb begin
    nextIndex  = index;
    doRefresh  = 1'b0;
    doGet      = 1'b0;
    doError    = 1'b0;
    errCode    = stackPkg::stNone;
    startClear = 1'b0;
    wrEn       = 1'b0;
    wrAddr     = index;
    wrData     = opData;
    if (busy) begin
      if (clrLast) begin
        // final cycle of the fill, pending push lands here
        wrEn      = clrPush;
        wrAddr    = clrTarget;
        wrData    = clrData;
        nextIndex = clrPush ? clrTarget + 1'b1 : clrTarget;
        doRefresh = 1'b1;
      end else begin
        wrEn   = 1'b1;
        wrAddr = clrAddr;
        wrData = '0;
      end
    end else if (opValid) begin
      case (op)
        stackPkg::opNone: doRefresh = 1'b1;
        stackPkg::opPush: begin
          if (index == topIndex) begin
            doError = 1'b1;
            errCode = stackPkg::stOverflow;
          end else begin
            wrEn      = 1'b1;
            nextIndex = index + 1'b1;
            doRefresh = 1'b1;
          end
        end
        stackPkg::opPop: begin
          if (popUnder) begin
            doError = 1'b1;
            errCode = stackPkg::stUnderflow;
          end else begin
            nextIndex = index - indexWidth'(opData) - 1'b1;
            doRefresh = 1'b1;
          end
        end
        stackPkg::opReplace: begin
          if (index <= underflowLimit) begin
            doError = 1'b1;
            errCode = stackPkg::stUnderflow;
          end else begin
            wrEn      = 1'b1;
            wrAddr    = index - 1'b1;
            doRefresh = 1'b1;
          end
        end
        stackPkg::opIndexReset, stackPkg::opIndexResetPush: begin
          if (op == stackPkg::opIndexResetPush && opOffset == topIndex) begin
            doError = 1'b1;
            errCode = stackPkg::stOverflow;
          end else if (opOffset > index) begin
            startClear = 1'b1; // first exposed entry cleared right away
            wrEn       = 1'b1;
            wrData     = '0;
          end else if (op == stackPkg::opIndexResetPush) begin
            wrEn      = 1'b1;
            wrAddr    = opOffset;
            nextIndex = opOffset + 1'b1;
            doRefresh = 1'b1;
          end else begin
            nextIndex = opOffset;
            doRefresh = 1'b1;
          end
        end
        stackPkg::opUnderflowGet: begin
          if (badOffset) begin
            doError = 1'b1;
            errCode = stackPkg::stBadOffset;
          end else begin
            doGet = 1'b1;
          end
        end
        stackPkg::opUnderflowSet: begin
          if (badOffset) begin
            doError = 1'b1;
            errCode = stackPkg::stBadOffset;
          end else if (dropTos && index == underflowLimit) begin
            doError = 1'b1;
            errCode = stackPkg::stUnderflow;
          end else begin
            wrEn      = 1'b1;
            wrAddr    = getAddr;
            nextIndex = dropTos ? index - 1'b1 : index;
            doRefresh = 1'b1;
          end
        end
      endcase
    end
  end

  // entries below zero map to the all-ones address
  always_comb begin
    rdAddrA = doGet ? getAddr : nextIndex - 1'b1;
    rdAddrB = (nextIndex >= indexWidth'(2)) ? nextIndex - indexWidth'(2) : '1;
    rdAddrC = (nextIndex >= indexWidth'(3)) ? nextIndex - indexWidth'(3) : '1;
  end

  // bypass the entry written on the same edge
  assign fwdA = (wrEn && wrAddr == rdAddrA) ? wrData : rdDataA;
  assign fwdB = (wrEn && wrAddr == rdAddrB) ? wrData : rdDataB;
  assign fwdC = (wrEn && wrAddr == rdAddrC) ? wrData : rdDataC;

  always_ff @(posedge clk) begin
    if (reset) begin
      index     <= '0;
      status    <= stackPkg::stEmpty;
      tos       <= '0;
      out1      <= '0;
      out2      <= '0;
      busy      <= 1'b0;
      clrAddr   <= '0;
      clrTarget <= '0;
      clrPush   <= 1'b0;
    end else begin
      if (doRefresh) begin
        index  <= nextIndex;
        status <= levelStatus(nextIndex, underflowLimit);
        tos    <= fwdA;
        out1   <= fwdB;
        out2   <= fwdC;
      end else if (doGet) begin
        tos    <= rdDataA;
        status <= stackPkg::stNone;
      end else if (doError) begin
        status <= errCode; // index and outputs stay
      end

      if (startClear) begin
        busy      <= 1'b1;
        clrAddr   <= index + 1'b1;
        clrTarget <= opOffset;
        clrPush   <= op == stackPkg::opIndexResetPush;
      end else if (busy) begin
        if (clrLast) begin
          busy <= 1'b0;
        end else begin
          clrAddr <= clrAddr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startClear) begin
      clrData <= opData;
    end
  end

endmodule

/* design/stackStorage.sv */
// stack storage
// entry array with one synchronous write port and three asynchronous
// read ports; the all-ones address lies past the last entry and reads
// as zero, which gives the empty slots below the bottom of the stack
`timescale 1ns/1ps

module stackStorage #(
  parameter int dataWidth = 8,
  parameter int depthLog2 = 3
) (
  input  logic                 clk,
  input  logic                 wrEn,
  input  logic [depthLog2:0]   wrAddr,
  input  logic [dataWidth-1:0] wrData,
  input  logic [depthLog2:0]   rdAddrA,
  input  logic [depthLog2:0]   rdAddrB,
  input  logic [depthLog2:0]   rdAddrC,
  output logic [dataWidth-1:0] rdDataA,
  output logic [dataWidth-1:0] rdDataB,
  output logic [dataWidth-1:0] rdDataC
);

  localparam int indexWidth = depthLog2 + 1;
  localparam int maxStack   = 2 ** indexWidth - 1;
  localparam logic [indexWidth-1:0] endAddr = indexWidth'(maxStack);

  logic [dataWidth-1:0] mem [maxStack];

  logic validA;
  logic validB;
  logic validC;

  always_ff @(posedge clk) begin
    if (wrEn && wrAddr < endAddr) begin
      mem[wrAddr] <= wrData;
    end
  end

  // out of range addresses read as zero
  assign validA = rdAddrA < endAddr;
  assign validB = rdAddrB < endAddr;
  assign validC = rdAddrC < endAddr;

  assign rdDataA = validA ? mem[rdAddrA] : '0;
  assign rdDataB = validB ? mem[rdAddrB] : '0;
  assign rdDataC = validC ? mem[rdAddrC] : '0;

endmodule

/* design/stackPkg.sv */
// stack package
// op codes, status codes and the APB register map shared by the stack
// subsystem and its testbench
package stackPkg;

  localparam int apbAddrWidth = 7;
  localparam int apbDataWidth = 32;

  // operation codes, as written to the command register
  localparam logic [2:0] opNone           = 3'd0;
  localparam logic [2:0] opPush           = 3'd1;
  localparam logic [2:0] opPop            = 3'd2;
  localparam logic [2:0] opReplace        = 3'd3;
  localparam logic [2:0] opIndexReset     = 3'd4;
  localparam logic [2:0] opIndexResetPush = 3'd5;
  localparam logic [2:0] opUnderflowGet   = 3'd6;
  localparam logic [2:0] opUnderflowSet   = 3'd7;

  // status codes
  localparam logic [2:0] stNone      = 3'd0;
  localparam logic [2:0] stEmpty     = 3'd1;
  localparam logic [2:0] stFull      = 3'd2;
  localparam logic [2:0] stUnderflow = 3'd3;
  localparam logic [2:0] stOverflow  = 3'd4;
  localparam logic [2:0] stBadOffset = 3'd5;

  // byte addresses of the word registers
  localparam logic [6:0] regData           = 7'h00;
  localparam logic [6:0] regOffset         = 7'h04;
  localparam logic [6:0] regUnderflowLimit = 7'h08;
  localparam logic [6:0] regUpperLimit     = 7'h0C;
  localparam logic [6:0] regLowerLimit     = 7'h10;
  localparam logic [6:0] regCommand        = 7'h14;
  localparam logic [6:0] regTos            = 7'h18; // read only from here on
  localparam logic [6:0] regOut1           = 7'h1C;
  localparam logic [6:0] regOut2           = 7'h20;
  localparam logic [6:0] regIndex          = 7'h24;
  localparam logic [6:0] regStatus         = 7'h28;

  // command register fields
  localparam int cmdOpLsb      = 0;
  localparam int cmdOpMsb      = 2;
  localparam int cmdDropTosBit = 3;

  // status register fields
  localparam int statusLsb     = 0;
  localparam int statusMsb     = 2;
  localparam int statusBusyBit = 8;

endpackage
